//--- all.f
+incdir+verification
src/drbg_pkg.sv
src/mac_pkg.sv
src/mac_if.sv
src/keyed_mix_core.sv
src/drbg_ctrl.sv
src/rand_fifo.sv
src/drbg_top.sv
verification/tb_drbg_top.sv

//--- Makefile
# Verilator flow for the DRBG project, run from the project root

TOP := tb_drbg_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module drbg_top -f all.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

# A $fatal in the testbench makes the binary, and so make, return failure
sim:
	verilator --binary --assert --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- verification/drbg_model.svh
// Reference model of the keyed mixer and the generation procedure, included by the DRBG testbench
`ifndef DRBG_MODEL_SVH
`define DRBG_MODEL_SVH

  // ------------------------------
  // Mixer constants and model state
  // ------------------------------
  localparam logic [31:0] REF_IV     = 32'h6a09e667;  // Folded into the key on a new message
  localparam int          REF_ROUNDS = 4;
  localparam int          RETRY_MAX  = 4096;          // Bound on rejections per word

  logic [31:0] m_k;
  logic [31:0] m_v;
  logic [7:0]  m_cnt;      // Generate counter, wraps like the byte it is
  logic [31:0] m_ent;
  logic [31:0] m_nonce;
  bit          m_first   = 1'b1;  // First round after init skips the counter bump
  bit          m_stuck   = 1'b0;
  int          m_rejects = 0;

  // One block through all rounds, state carried in and out
  function automatic logic [31:0] mix_block(input logic [31:0] s_in, input logic [31:0] key,
                                            input logic [63:0] blk);
    logic [31:0] s;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    s = s_in;
    a = blk[63:32];  // High word is added first
    b = blk[31:0];
    for (int r = 0; r < REF_ROUNDS; r++) begin
      sum    = s + a;
      s      = {sum[24:0], sum[31:25]} ^ b ^ key;  // Rotate left by 7
      {a, b} = {b, a};
    end
    return s;
  endfunction

  // Two block key message, second block continues the state
  function automatic logic [31:0] key_update(input logic [31:0] k, input logic [31:0] v,
                                             input logic [7:0] cnt);
    logic [31:0] s;
    s = mix_block(k ^ REF_IV, k, {v, cnt, m_ent[31:8]});
    return mix_block(s, k, {m_ent[7:0], m_nonce, 24'h68});
  endfunction

  function automatic logic [31:0] v_update(input logic [31:0] k, input logic [31:0] v);
    return mix_block(k ^ REF_IV, k, {v, 32'h20});
  endfunction

  // Retry key after a rejected candidate
  function automatic logic [31:0] k3_update(input logic [31:0] k, input logic [31:0] v);
    return mix_block(k ^ REF_IV, k, {v, 8'h00, 24'h28});
  endfunction

  function automatic void model_start(input logic [31:0] ent, input logic [31:0] non);
    m_k       = '0;
    m_v       = 32'h01010101;
    m_cnt     = '0;
    m_ent     = ent;
    m_nonce   = non;
    m_first   = 1'b1;
    m_rejects = 0;
    m_stuck   = 1'b0;
  endfunction

  // ------------------------------
  // One generate round, returns the accepted word
  // ------------------------------
  function automatic logic [31:0] next_word(input logic [31:0] limit);
    logic [31:0] t;
    int          tries;
    if (!m_first) m_cnt = m_cnt + 8'd1;  // Bump at the start of every later round
    m_first = 1'b0;
    m_k     = key_update(m_k, m_v, m_cnt);
    m_v     = v_update(m_k, m_v);
    m_cnt   = m_cnt + 8'd1;
    m_k     = key_update(m_k, m_v, m_cnt);
    m_v     = v_update(m_k, m_v);
    t       = v_update(m_k, m_v);  // Candidate
    tries   = 0;
    while (!((t != '0) && (t < limit)) && (tries < RETRY_MAX)) begin
      m_k = k3_update(m_k, m_v);
      m_v = v_update(m_k, m_v);
      t   = v_update(m_k, m_v);
      m_rejects++;
      tries++;
    end
    if (!((t != '0) && (t < limit))) m_stuck = 1'b1;
    m_v = v_update(m_k, t);  // V refreshed from the accepted word
    return t;
  endfunction

`endif

//--- verification/tb_drbg_top.sv
// Self-checking testbench for the DRBG top level, built and run by the simulation target
`timescale 1ns/100ps
`default_nettype none

module tb_drbg_top;
  localparam logic [31:0] LIMIT        = 32'h40000000;  // Low bound, so rejections are common
  localparam int          DEPTH        = 8;
  localparam int          RAND_WORDS   = 40;
  localparam int          RESEED_WORDS = 12;
  localparam int          ZERO_WORDS   = 6;
  localparam int          TOTAL_WORDS  = DEPTH + RAND_WORDS + RESEED_WORDS + ZERO_WORDS;
  localparam int          CASES        = 5;
  localparam int          ROUND_NS     = 1000;          // Worst case round with retries
  localparam int          TIMEOUT_NS   = CASES * RAND_WORDS * ROUND_NS;

  logic        clk = 1'b0;
  logic        reset_n;
  logic        zeroize;
  logic        init_cmd;
  logic        pop;
  logic [31:0] entropy;
  logic [31:0] nonce;
  logic        ready;
  logic        empty;
  logic [31:0] rd_data;

  string       test_name;
  logic [31:0] expected;
  logic [31:0] exp_q[$];   // Expected words, oldest first
  int          pop_count = 0;

  `include "drbg_model.svh"

  drbg_top #(
    .MIX_ROUNDS (REF_ROUNDS),
    .FIFO_DEPTH (DEPTH),
    .DRBG_LIMIT (LIMIT)
  ) uut (
    .clk      (clk),
    .reset_n  (reset_n),
    .zeroize  (zeroize),
    .init_cmd (init_cmd),
    .pop      (pop),
    .entropy  (entropy),
    .nonce    (nonce),
    .ready    (ready),
    .empty    (empty),
    .rd_data  (rd_data)
  );

  always #2 clk = ~clk;  // 4 ns period

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Inputs change just after the edge
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    assert (act === exp) else
      report_failure($sformatf("FAIL %s %s expected %0b actual %0b", test_name, what, exp, act));
  endtask

  // Holds init_cmd until the controller takes it, then restarts the model
  task automatic issue_init(input logic [31:0] ent, input logic [31:0] non);
    bit taken;
    entropy  = ent;
    nonce    = non;
    init_cmd = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = ready;  // Level seen here is the one the next edge samples
      next_cycle();
    end
    init_cmd = 1'b0;
    model_start(ent, non);
    exp_q.delete();
  endtask

  task automatic pop_words(input int n, input int max_gap);
    int gap;
    for (int i = 0; i < n; i++) begin
      while (empty) next_cycle();
      pop = 1'b1;
      next_cycle();
      pop = 1'b0;
      gap = (max_gap > 0) ? int'($urandom % max_gap) : 0;
      repeat (gap) next_cycle();
    end
  endtask

  // Pops a full buffer on consecutive cycles and expects a word every time
  task automatic drain_full(input int n);
    for (int i = 0; i < n; i++) begin
      check_level("empty during full drain", 1'b0, empty);
      pop = 1'b1;
      next_cycle();
      pop = 1'b0;
    end
  endtask

  // Full buffer keeps the controller in IDLE, so ready stays up
  task automatic wait_for_hold();
    int run;
    run = 0;
    while (run < 4) begin
      run = ready ? run + 1 : 0;
      next_cycle();
    end
  endtask

  // ------------------------------
  // Comparing process, pop is stable at the falling edge
  // ------------------------------
  always @(negedge clk) begin
    if (reset_n && !zeroize && pop && !empty) begin
      if (exp_q.size() == 0) exp_q.push_back(next_word(LIMIT));
      expected = exp_q.pop_front();
      assert (!m_stuck) else
        report_failure("Reference model found no accepted word within its retry bound");
      assert (rd_data === expected) else
        report_failure($sformatf("FAIL %s expected %08h actual %08h",
                                 test_name, expected, rd_data));
      pop_count++;
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    report_failure("Timeout, the DUT stopped answering before all tests finished");
  end

  // ------------------------------
  // Scenarios
  // ------------------------------
  initial begin
    void'($urandom(32'h4d9c_c2a5));
    reset_n   = 1'b0;
    zeroize   = 1'b0;
    init_cmd  = 1'b0;
    pop       = 1'b0;
    entropy   = '0;
    nonce     = '0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    check_level("ready in reset", 1'b0, ready);
    #1 reset_n = 1'b1;

    test_name = "idle_after_reset";
    while (!ready) next_cycle();
    repeat (40) begin
      check_level("empty", 1'b1, empty);  // Nothing generated without init
      check_level("ready", 1'b1, ready);
      next_cycle();
    end

    test_name = "fill_and_hold";
    issue_init($urandom, $urandom);
    wait_for_hold();
    check_level("empty when full", 1'b0, empty);
    drain_full(DEPTH);
    check_level("empty after drain", 1'b1, empty);  // A round is far longer than the drain

    test_name = "random_gaps";
    pop_words(RAND_WORDS, 8);
    assert (m_rejects > 0) else
      report_failure("No round in the random gap test took the rejection path");

    test_name = "reseed";
    issue_init($urandom, $urandom);
    next_cycle();
    check_level("empty after flush", 1'b1, empty);
    pop_words(RESEED_WORDS, 4);

    test_name = "zeroize";
    issue_init($urandom, $urandom);
    while (empty) next_cycle();
    repeat (10) next_cycle();  // Second round under way
    zeroize = 1'b1;
    next_cycle();
    zeroize = 1'b0;
    check_level("empty after zeroize", 1'b1, empty);
    check_level("ready after zeroize", 1'b0, ready);
    while (!ready) next_cycle();
    pop = 1'b1;  // Pop on an empty buffer
    repeat (3) next_cycle();
    pop = 1'b0;
    check_level("empty after idle pop", 1'b1, empty);
    check_level("ready after idle pop", 1'b1, ready);
    issue_init($urandom, $urandom);
    pop = 1'b1;
    repeat (3) next_cycle();
    pop = 1'b0;
    pop_words(ZERO_WORDS, 3);

    if (pop_count == TOTAL_WORDS) begin
      $display("Simulation passed");
      $finish;
    end else begin
      report_failure($sformatf("FAIL %s expected %0d words actual %0d",
                               test_name, TOTAL_WORDS, pop_count));
    end
  end

endmodule

`default_nettype wire

//--- src/drbg_top.sv
// DRBG top level, ties controller, mixing engine and output buffer to plain ports
`timescale 1ns/100ps
`default_nettype none

module drbg_top #(
  parameter int unsigned                 MIX_ROUNDS = 4,            // Rounds per block
  parameter int unsigned                 FIFO_DEPTH = 8,            // Buffered words
  parameter logic [drbg_pkg::WORD_W-1:0] DRBG_LIMIT = 32'hfffffff1  // Acceptance bound
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        zeroize,
  input  logic                        init_cmd,
  input  logic                        pop,
  input  logic [drbg_pkg::WORD_W-1:0] entropy,
  input  logic [drbg_pkg::WORD_W-1:0] nonce,
  output logic                        ready,
  output logic                        empty,
  output logic [drbg_pkg::WORD_W-1:0] rd_data
);
  import drbg_pkg::*;

  logic              push;
  logic              flush;
  logic              full;
  logic [WORD_W-1:0] push_data;

  mac_if mac ();  // Controller to engine bundle

  // ------------------------------
  // Sequencer
  // ------------------------------
  drbg_ctrl #(
    .DRBG_LIMIT (DRBG_LIMIT)
  ) u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .init_cmd  (init_cmd),
    .entropy   (entropy),
    .nonce     (nonce),
    .ready     (ready),
    .mac       (mac.ctrl),
    .push      (push),
    .flush     (flush),
    .push_data (push_data),
    .full      (full)
  );

  // Mixing engine
  keyed_mix_core #(
    .MIX_ROUNDS (MIX_ROUNDS)
  ) u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .mac     (mac.core)
  );

  // Word buffer, read side is the top level port
  rand_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .flush     (flush),
    .push      (push),
    .pop       (pop),
    .push_data (push_data),
    .full      (full),
    .empty     (empty),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

//--- src/rand_fifo.sv
// Output buffer for generated words, filled by the controller and drained through pop
`timescale 1ns/100ps
`default_nettype none

module rand_fifo #(
  parameter int unsigned FIFO_DEPTH = 8  // Power of two
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        zeroize,
  input  logic                        flush,
  input  logic                        push,
  input  logic                        pop,
  input  logic [drbg_pkg::WORD_W-1:0] push_data,
  output logic                        full,
  output logic                        empty,
  output logic [drbg_pkg::WORD_W-1:0] rd_data
);
  import drbg_pkg::*;

  localparam int unsigned AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]     wr_ptr_q;
  logic [AW-1:0]     rd_ptr_q;
  logic [AW:0]       count_q;  // One extra bit to tell full from empty
  logic              do_push;
  logic              do_pop;

  assign full    = (count_q == (AW+1)'(FIFO_DEPTH));
  assign empty   = (count_q == '0);
  assign do_push = push && !full;   // Dropped when full
  assign do_pop  = pop && !empty;   // Ignored when empty
  assign rd_data = mem[rd_ptr_q];   // Oldest word

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr_q] <= push_data;
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n || zeroize) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      wr_ptr_q <= '0;  // Drop everything buffered
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/drbg_ctrl.sv
// DRBG sequencer, drives K and V updates through the mix engine and pushes accepted words
`timescale 1ns/100ps
`default_nettype none

module drbg_ctrl #(
  parameter logic [drbg_pkg::WORD_W-1:0] DRBG_LIMIT = 32'hfffffff1  // Accept below this
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        zeroize,
  input  logic                        init_cmd,
  input  logic [drbg_pkg::WORD_W-1:0] entropy,
  input  logic [drbg_pkg::WORD_W-1:0] nonce,
  output logic                        ready,
  mac_if.ctrl                         mac,
  output logic                        push,
  output logic                        flush,
  output logic [drbg_pkg::WORD_W-1:0] push_data,
  input  logic                        full
);
  import drbg_pkg::*;
  import mac_pkg::*;

  drbg_state_e        state_q;
  drbg_state_e        state_last_q;  // State one cycle ago
  drbg_state_e        state_d;
  logic               first_round;   // First cycle in a state
  logic               tv_last_q;
  logic               tv_edge;       // Engine just finished
  logic               accept;
  logic               seeded_q;      // Init seen, auto generation on
  logic               cmd_req;
  mac_op_e            cmd_op;
  logic [WORD_W-1:0]  k_q;
  logic [WORD_W-1:0]  v_q;
  logic [CNT_W-1:0]   cnt_q;

  // ------------------------------
  // Edge detection
  // ------------------------------
  assign first_round = (state_q != state_last_q);
  assign tv_edge     = mac.tag_valid & ~tv_last_q;

  // Candidate range check, rejects zero and anything at or above limit
  assign accept = (mac.tag != '0) && (mac.tag < DRBG_LIMIT);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n || zeroize) begin
      state_q      <= IDLE;
      state_last_q <= IDLE;
      tv_last_q    <= 1'b0;
    end else begin
      state_q      <= state_d;
      state_last_q <= state_q;
      tv_last_q    <= mac.tag_valid;
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (ready && init_cmd) state_d = INIT;
        else if (seeded_q && !full && mac.ready) state_d = NEXT;  // Wait while full
      end
      INIT:    state_d = K10;
      NEXT:    state_d = K10;
      K10:     if (tv_edge) state_d = K11;
      K11:     if (tv_edge) state_d = V1;
      V1:      if (tv_edge) state_d = K2_INIT;
      K2_INIT: state_d = K20;
      K20:     if (tv_edge) state_d = K21;
      K21:     if (tv_edge) state_d = V2;
      V2:      if (tv_edge) state_d = T;
      T:       if (tv_edge) state_d = CHCK;
      CHCK:    state_d = accept ? DONE : K3;
      K3:      if (tv_edge) state_d = V3;
      V3:      if (tv_edge) state_d = T;  // Retry candidate
      DONE:    if (tv_edge) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // ------------------------------
  // Engine command per state
  // ------------------------------
  always_comb begin
    cmd_req = 1'b1;
    cmd_op  = MAC_INIT;
    unique case (state_q)
      K10, V1, K20, V2, T, K3, V3, DONE: cmd_op = MAC_INIT;
      K11, K21:                          cmd_op = MAC_NEXT;  // Second block of K message
      default:                           cmd_req = 1'b0;
    endcase
  end

  // Strobes go out the cycle after state entry, block already stable
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n || zeroize) begin
      mac.init <= 1'b0;
      mac.next <= 1'b0;
    end else begin
      mac.init <= first_round && cmd_req && (cmd_op == MAC_INIT);
      mac.next <= first_round && cmd_req && (cmd_op == MAC_NEXT);
    end
  end

  // Message blocks, high word first
  always_comb begin
    unique case (state_q)
      K10, K20:            mac.block = {v_q, cnt_q, entropy[WORD_W-1:8]};
      K11, K21:            mac.block = {entropy[7:0], nonce, LENGTH_K};
      V1, V2, T, V3, DONE: mac.block = {v_q, LENGTH_V};
      K3:                  mac.block = {v_q, 8'h00, LENGTH_K3};
      default:             mac.block = '0;
    endcase
  end

  assign mac.key = k_q;

  // ------------------------------
  // K, V and counter
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n || zeroize) begin
      k_q      <= '0;
      v_q      <= '0;
      cnt_q    <= '0;
      seeded_q <= 1'b0;
    end else if (first_round) begin
      unique case (state_q)
        INIT: begin
          k_q      <= K_INIT;
          v_q      <= V_INIT;
          cnt_q    <= '0;
          seeded_q <= 1'b1;
        end
        NEXT:         cnt_q <= cnt_q + 1'b1;
        K2_INIT: begin
          v_q   <= mac.tag;  // V from first V update
          cnt_q <= cnt_q + 1'b1;
        end
        V1, V2, V3:   k_q <= mac.tag;  // Key from finished K message
        T, DONE:      v_q <= mac.tag;  // T entry takes V, DONE entry takes T
        default:      k_q <= k_q;
      endcase
    end else if (state_q == DONE && tv_edge) begin
      v_q <= mac.tag;  // V refreshed from the accepted word
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign ready     = (state_q == IDLE) && mac.ready;
  assign flush     = (state_q == INIT);
  assign push      = (state_q == DONE) && first_round;
  assign push_data = mac.tag;  // Still the accepted candidate on push

endmodule

`default_nettype wire

//--- src/keyed_mix_core.sv
// Round based keyed mixer, folds 64 bit blocks into a 32 bit tag under a 32 bit key
`timescale 1ns/100ps
`default_nettype none

module keyed_mix_core #(
  parameter int unsigned MIX_ROUNDS = 4  // Rounds per block
) (
  input logic clk,
  input logic reset_n,
  input logic zeroize,
  mac_if.core mac
);
  import mac_pkg::*;

  localparam int unsigned RND_W = (MIX_ROUNDS > 1) ? $clog2(MIX_ROUNDS) : 1;

  mac_state_e       state_q;
  mac_op_e          op;
  logic             strobe;
  logic [MIX_W-1:0] s_q;      // Mixing state, also the tag
  logic [MIX_W-1:0] key_q;
  logic [MIX_W-1:0] a_q;      // Word added this round
  logic [MIX_W-1:0] b_q;      // Word XOR-ed this round
  logic [MIX_W-1:0] sum;
  logic [MIX_W-1:0] rnd_out;
  logic [RND_W-1:0] rnd_q;
  logic             last_rnd;

  // ------------------------------
  // Command decode and round function
  // ------------------------------
  assign strobe = mac.init | mac.next;
  assign op     = mac.init ? MAC_INIT : MAC_NEXT;  // init wins if both

  assign sum      = s_q + a_q;  // Modulo 2^32
  assign rnd_out  = ((sum << MIX_ROT) | (sum >> (MIX_W - MIX_ROT))) ^ b_q ^ key_q;
  assign last_rnd = (rnd_q == RND_W'(MIX_ROUNDS - 1));

  // ------------------------------
  // Engine sequencing
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n || zeroize) begin
      state_q       <= MAC_IDLE;
      mac.ready     <= 1'b0;
      mac.tag_valid <= 1'b0;
      s_q           <= '0;
      key_q         <= '0;
      a_q           <= '0;
      b_q           <= '0;
      rnd_q         <= '0;
    end else begin
      unique case (state_q)
        MAC_IDLE, MAC_DONE: begin
          mac.ready <= 1'b1;  // Ready one cycle after reset
          if (strobe) begin
            key_q         <= mac.key;
            a_q           <= mac.block[BLOCK_W-1:BLOCK_W/2];  // High word first
            b_q           <= mac.block[BLOCK_W/2-1:0];
            if (op == MAC_INIT) s_q <= mac.key ^ MIX_IV;     // MAC_NEXT keeps S
            rnd_q         <= '0;
            mac.ready     <= 1'b0;
            mac.tag_valid <= 1'b0;
            state_q       <= MAC_BUSY;
          end
        end
        MAC_BUSY: begin
          s_q   <= rnd_out;
          a_q   <= b_q;  // Words swap every round
          b_q   <= a_q;
          rnd_q <= rnd_q + 1'b1;
          if (last_rnd) begin
            mac.ready     <= 1'b1;
            mac.tag_valid <= 1'b1;
            state_q       <= MAC_DONE;
          end
        end
        default: state_q <= MAC_IDLE;
      endcase
    end
  end

  assign mac.tag = s_q;

endmodule

`default_nettype wire

//--- src/mac_if.sv
// Command and result bundle between the DRBG controller and the keyed mixing engine
`timescale 1ns/100ps
`default_nettype none

interface mac_if;
  import mac_pkg::*;

  // Controller to engine
  logic               init;   // One cycle strobe, new message
  logic               next;   // One cycle strobe, next block of message
  logic [MIX_W-1:0]   key;    // Held by controller for whole message
  logic [BLOCK_W-1:0] block;  // Sampled on the strobe cycle

  // Engine to controller
  logic               ready;      // Engine can take a strobe
  logic [MIX_W-1:0]   tag;        // Running state, final once tag_valid
  logic               tag_valid;  // Level, high until next strobe

  modport ctrl (output init, next, key, block, input ready, tag, tag_valid);

  modport core (input init, next, key, block, output ready, tag, tag_valid);

endinterface

`default_nettype wire

//--- src/mac_pkg.sv
// Mixing engine constants, command opcodes and engine states for the keyed mix core and its users
`default_nettype none

package mac_pkg;

  // ------------------------------
  // Engine geometry
  // ------------------------------
  localparam int unsigned MIX_W   = 32;  // Key, state and tag width
  localparam int unsigned BLOCK_W = 64;  // Message block, high word then low word

  localparam logic [MIX_W-1:0] MIX_IV  = 32'h6a09e667;  // Folded into the key at init
  localparam int unsigned      MIX_ROT = 7;             // Rotate left per round

  // Command carried by the init and next strobes
  typedef enum logic {
    MAC_INIT,  // Start a message, state from key
    MAC_NEXT   // Continue a message, state kept
  } mac_op_e;

  // Engine sequencing
  typedef enum logic [1:0] {
    MAC_IDLE,  // Nothing computed since reset
    MAC_BUSY,  // Rounds in progress
    MAC_DONE   // Tag held until next strobe
  } mac_state_e;

endpackage

`default_nettype wire

//--- src/drbg_pkg.sv
// Generator sizes, controller states and K/V start values shared by the DRBG controller and top
`default_nettype none

package drbg_pkg;

  // ------------------------------
  // Datapath sizes
  // ------------------------------
  localparam int unsigned WORD_W = 32;  // K, V, entropy, nonce and output words
  localparam int unsigned CNT_W  = 8;   // Generate counter, one byte of the K message

  // ------------------------------
  // Start values and length markers
  // ------------------------------
  localparam logic [WORD_W-1:0] K_INIT = '0;            // K starts all zero
  localparam logic [WORD_W-1:0] V_INIT = 32'h01010101;  // Every byte 01

  localparam logic [31:0] LENGTH_V  = 32'h20;  // 32 bit message, V only
  localparam logic [23:0] LENGTH_K  = 24'h68;  // 104 bit message over two blocks
  localparam logic [23:0] LENGTH_K3 = 24'h28;  // 40 bit message, V and a zero byte

  // Controller sequence, one state per engine command
  typedef enum logic [3:0] {
    IDLE,     // Wait for init or start an automatic round
    INIT,     // Load K, V and counter start values
    NEXT,     // Bump counter for a new generate round
    K10,      // K update, first block
    K11,      // K update, second block
    V1,       // V update after first K
    K2_INIT,  // Counter bump between the two updates
    K20,      // Second K update, first block
    K21,      // Second K update, second block
    V2,       // V update after second K
    T,        // Candidate word from V
    CHCK,     // Range check of the candidate
    K3,       // Retry key from V and a zero byte
    V3,       // V update after retry key
    DONE      // Push word, refresh V
  } drbg_state_e;

endpackage

`default_nettype wire
